// File: phy_io_pkg.sv
// PHY datapath definitions
package phy_io_pkg;

	// Group and slot geometry of the AFI buses
	localparam int NUM_DQS_GROUPS = 2;
	localparam int DQ_PER_GROUP = 8;
	localparam int NUM_SLOTS = 4;
	localparam int NUM_HALVES = 2;

	// Read path sizing
	localparam int RD_LAT_W = 5;
	localparam int EXTRA_VFIFO_SHIFT = 1;
	localparam int LFIFO_DEPTH = 8;

	// Derived sizes
	localparam int RD_DLY_DEPTH = 1 << RD_LAT_W;
	localparam int LFIFO_PTR_W = $clog2(LFIFO_DEPTH);
	localparam int LFIFO_CNT_W = $clog2(LFIFO_DEPTH + 1);

	typedef logic [DQ_PER_GROUP-1:0] dq_lane_t;

	// Slot-major buses, slot 0 of group 0 in the low bits
	typedef logic [NUM_SLOTS*NUM_DQS_GROUPS*DQ_PER_GROUP-1:0] afi_wdata_t;
	typedef logic [NUM_HALVES*NUM_DQS_GROUPS-1:0] afi_grp_bits_t;
	typedef logic [NUM_SLOTS*NUM_DQS_GROUPS-1:0] afi_dm_t;

	typedef logic [RD_LAT_W-1:0] rd_lat_t;

	// Group 0 occupies the low byte
	typedef logic [NUM_DQS_GROUPS*DQ_PER_GROUP-1:0] afi_rdata_t;

	typedef struct packed {
		afi_grp_bits_t wrdata_en;
		afi_grp_bits_t dqs_en;
		afi_grp_bits_t oct_ena;
	} wr_ctrl_t;

	// One DQS group's write lane, beat 0 and half 0 in the low bits of each field
	typedef struct packed {
		dq_lane_t [NUM_SLOTS-1:0] dq;
		logic [NUM_SLOTS-1:0] dm;
		logic [NUM_HALVES-1:0] oe;
		logic [NUM_HALVES-1:0] dqs_en;
		logic [NUM_HALVES-1:0] oct_ena;
	} grp_wr_t;

endpackage

// File: phy_io_top.sv
// PHY I/O datapath top
`timescale 1ns/1ps

module phy_io_top import phy_io_pkg::*; (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,

	input afi_wdata_t afi_wdata,
	input afi_dm_t afi_dm,
	input wr_ctrl_t wr_ctrl,

	input logic afi_rdata_en_full,
	input rd_lat_t rd_latency,
	input afi_rdata_t mem_rdata,

	output grp_wr_t [NUM_DQS_GROUPS-1:0] grp_wr,
	output afi_rdata_t afi_rdata,
	output logic afi_rdata_valid
);

	logic qvld;
	logic pop;
	logic [NUM_DQS_GROUPS-1:0] lane_valid;
	dq_lane_t [NUM_DQS_GROUPS-1:0] lane_rdata;
	dq_lane_t [NUM_DQS_GROUPS-1:0] mem_lane;

	// Write side regrouping
	wr_lane_mux u_wr (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_wdata (afi_wdata),
		.afi_dm (afi_dm),
		.wr_ctrl (wr_ctrl),
		.grp_wr (grp_wr)
	);

	rd_valid_ctrl u_ctrl (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_en_full (afi_rdata_en_full),
		.rd_latency (rd_latency),
		.lane_valid (lane_valid),
		.qvld (qvld),
		.pop (pop),
		.afi_rdata_valid (afi_rdata_valid)
	);

	assign mem_lane = mem_rdata;
	assign afi_rdata = lane_rdata;

	// One latency FIFO per DQS group, all sharing push and pop
	for (genvar g = 0; g < NUM_DQS_GROUPS; g++) begin : g_lfifo
		rd_latency_fifo u_lfifo (
			.pll_afi_clk (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.push (qvld),
			.pop (pop),
			.wdata (mem_lane[g]),
			.lane_rdata (lane_rdata[g]),
			.lane_valid (lane_valid[g])
		);
	end

endmodule

// File: project.f
phy_io_pkg.sv
wr_lane_mux.sv
rd_valid_ctrl.sv
rd_latency_fifo.sv
phy_io_top.sv
tb_phy_io_sva.sv
tb_phy_io.sv

// File: rd_latency_fifo.sv
// Read latency FIFO for one DQS group
`timescale 1ns/1ps

module rd_latency_fifo import phy_io_pkg::*; (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,

	input logic push,
	input logic pop,
	input dq_lane_t wdata,

	output dq_lane_t lane_rdata,
	output logic lane_valid
);

	dq_lane_t mem [LFIFO_DEPTH];
	dq_lane_t head_q;

	logic [LFIFO_PTR_W-1:0] wr_ptr;
	logic [LFIFO_PTR_W-1:0] rd_ptr;
	logic [LFIFO_CNT_W-1:0] count;

	logic full;
	logic empty;
	logic do_push;
	logic do_pop;

	assign full = (count == LFIFO_CNT_W'(LFIFO_DEPTH));
	assign empty = (count == '0);

	// Pushes into a full FIFO are lost and pops on an empty one return nothing
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge pll_afi_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The head is read on a pop and reaches lane_rdata together with the
	// registered valid, so back-to-back pops stay in step with afi_rdata_valid
	always_ff @(posedge pll_afi_clk) begin
		if (do_pop) begin
			head_q <= mem[rd_ptr];
		end
		if (lane_valid) begin
			lane_rdata <= head_q;
		end
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			lane_valid <= 1'b0;
		end else begin
			lane_valid <= do_pop;
		end
	end

endmodule

// File: rd_valid_ctrl.sv
// Read enable and valid control
`timescale 1ns/1ps

module rd_valid_ctrl import phy_io_pkg::*; (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,

	input logic afi_rdata_en_full,
	input rd_lat_t rd_latency,
	input logic [NUM_DQS_GROUPS-1:0] lane_valid,

	output logic qvld,
	output logic pop,
	output logic afi_rdata_valid
);

	logic [EXTRA_VFIFO_SHIFT-1:0] vfifo_shift;
	logic [RD_DLY_DEPTH-1:0] en_dly;

	// Extra VFIFO shift on the full-rate read enable
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			vfifo_shift <= '0;
		end else begin
			vfifo_shift[0] <= afi_rdata_en_full;
			for (int i = 1; i < EXTRA_VFIFO_SHIFT; i++) begin
				vfifo_shift[i] <= vfifo_shift[i-1];
			end
		end
	end

	// The delayed enable marks the cycle in which the memory data arrives
	assign qvld = vfifo_shift[EXTRA_VFIFO_SHIFT-1];

	// Latency delay line, one stage per AFI cycle
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			en_dly <= '0;
		end else begin
			en_dly <= {en_dly[RD_DLY_DEPTH-2:0], afi_rdata_en_full};
		end
	end

	// Stage j holds the enable sampled j edges ago, so the tap at rd_latency
	// is high rd_latency cycles after the sampling edge
	assign pop = en_dly[rd_latency];

	// A word is valid only once every group has delivered its byte
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			afi_rdata_valid <= 1'b0;
		end else begin
			afi_rdata_valid <= &lane_valid;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_phy_io -o sim_phy_io

out=$(./obj_dir/sim_phy_io 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Test completed successfully"; then
	exit 0
else
	exit 1
fi

// File: tb_phy_io.sv
// PHY datapath testbench
`timescale 1ns/1ps

module tb_phy_io import phy_io_pkg::*; ();

	localparam int NUM_ROWS = 64;
	localparam int TIMEOUT_CYCLES = NUM_ROWS + 40;

	typedef struct packed {
		afi_wdata_t wdata;
		afi_dm_t dm;
		wr_ctrl_t ctrl;
		logic rd_en;
		rd_lat_t lat;
		afi_rdata_t mdata;
		grp_wr_t [NUM_DQS_GROUPS-1:0] exp_wr;
	} row_t;

	typedef struct packed {
		int cycle;
		afi_rdata_t data;
	} rd_exp_t;

	logic pll_afi_clk = 1'b0;
	logic reset_n_afi_clk;
	afi_wdata_t afi_wdata;
	afi_dm_t afi_dm;
	wr_ctrl_t wr_ctrl;
	logic afi_rdata_en_full;
	rd_lat_t rd_latency;
	afi_rdata_t mem_rdata;
	grp_wr_t [NUM_DQS_GROUPS-1:0] grp_wr;
	afi_rdata_t afi_rdata;
	logic afi_rdata_valid;

	row_t rows [NUM_ROWS];
	rd_exp_t exp_q [$];
	logic [15:0] lfsr_state;
	int cycle_count = 0;

	phy_io_top dut0 (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_wdata (afi_wdata),
		.afi_dm (afi_dm),
		.wr_ctrl (wr_ctrl),
		.afi_rdata_en_full (afi_rdata_en_full),
		.rd_latency (rd_latency),
		.mem_rdata (mem_rdata),
		.grp_wr (grp_wr),
		.afi_rdata (afi_rdata),
		.afi_rdata_valid (afi_rdata_valid)
	);

	always #4 pll_afi_clk = ~pll_afi_clk;

	always @(posedge pll_afi_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$fatal(1);
		end
	end

	// Galois LFSR with taps 16, 14, 13 and 11, one step per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			if (lfsr_state[0]) begin
				lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
			end else begin
				lfsr_state = lfsr_state >> 1;
			end
			v[i] = lfsr_state[0];
		end
		return v;
	endfunction

	// Single read, then a burst with gaps, then reads at the minimum latency
	function automatic logic read_row(input int i);
		case (i)
			4, 18, 19, 20, 21, 24, 26, 27, 30, 42, 43, 46: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic rd_lat_t latency_for_row(input int i);
		if (i < 16) begin
			return 5'd4;
		end else if (i < 40) begin
			return 5'd6;
		end
		return 5'd2;
	endfunction

	task automatic expect_true(input bit ok, input string msg);
		assert (ok) else begin
			$display("ERROR at %0t ns: %s", $time, msg);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic build_table();
		logic [63:0] bits;
		int slot;
		int grp;
		for (int i = 0; i < NUM_ROWS; i++) begin
			rows[i].wdata = rand_bits($bits(afi_wdata_t));
			bits = rand_bits($bits(afi_dm_t));
			rows[i].dm = bits[$bits(afi_dm_t)-1:0];
			bits = rand_bits($bits(wr_ctrl_t));
			rows[i].ctrl = bits[$bits(wr_ctrl_t)-1:0];
			bits = rand_bits($bits(afi_rdata_t));
			rows[i].mdata = bits[$bits(afi_rdata_t)-1:0];
			rows[i].rd_en = read_row(i);
			rows[i].lat = latency_for_row(i);
			rows[i].exp_wr = '0;
			// Bus index b is slot b / groups, group b % groups
			for (int b = 0; b < NUM_SLOTS*NUM_DQS_GROUPS; b++) begin
				slot = b / NUM_DQS_GROUPS;
				grp = b % NUM_DQS_GROUPS;
				rows[i].exp_wr[grp].dq[slot] = rows[i].wdata[b*DQ_PER_GROUP +: DQ_PER_GROUP];
				rows[i].exp_wr[grp].dm[slot] = rows[i].dm[b];
			end
			for (int b = 0; b < NUM_HALVES*NUM_DQS_GROUPS; b++) begin
				slot = b / NUM_DQS_GROUPS;
				grp = b % NUM_DQS_GROUPS;
				rows[i].exp_wr[grp].oe[slot] = rows[i].ctrl.wrdata_en[b];
				rows[i].exp_wr[grp].dqs_en[slot] = rows[i].ctrl.dqs_en[b];
				rows[i].exp_wr[grp].oct_ena[slot] = rows[i].ctrl.oct_ena[b];
			end
		end
	endtask

	task automatic apply_row(input int n);
		rd_exp_t entry;
		afi_wdata = rows[n].wdata;
		afi_dm = rows[n].dm;
		wr_ctrl = rows[n].ctrl;
		afi_rdata_en_full = rows[n].rd_en;
		rd_latency = rows[n].lat;
		mem_rdata = rows[n].mdata;
		// Data comes from the row after the extra shift, valid after latency plus two
		if (rows[n].rd_en) begin
			entry.cycle = n + int'(rows[n].lat) + 2;
			entry.data = rows[n + EXTRA_VFIFO_SHIFT].mdata;
			exp_q.push_back(entry);
		end
	endtask

	task automatic check_read(input int obs);
		rd_exp_t head;
		if (exp_q.size() > 0 && exp_q[0].cycle == obs) begin
			head = exp_q.pop_front();
			expect_true(afi_rdata_valid === 1'b1,
				$sformatf("row %0d afi_rdata_valid low where a read is due", obs));
			expect_true(afi_rdata === head.data,
				$sformatf("row %0d afi_rdata %h, expected %h", obs, afi_rdata, head.data));
		end else begin
			expect_true(afi_rdata_valid === 1'b0,
				$sformatf("row %0d afi_rdata_valid high with no read due", obs));
		end
	endtask

	initial begin
		reset_n_afi_clk = 1'b1;
		afi_wdata = '0;
		afi_dm = '0;
		wr_ctrl = '0;
		afi_rdata_en_full = 1'b0;
		rd_latency = 5'd4;
		mem_rdata = '0;
		lfsr_state = 16'd29810;
		build_table();
		#1 reset_n_afi_clk = 1'b0;
		repeat (2) @(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		for (int g = 0; g < NUM_DQS_GROUPS; g++) begin
			expect_true(grp_wr[g].oe == '0 && grp_wr[g].dqs_en == '0 && grp_wr[g].oct_ena == '0,
				$sformatf("group %0d enables not cleared in reset", g));
		end
		expect_true(afi_rdata_valid == 1'b0, "afi_rdata_valid high in reset");
		reset_n_afi_clk = 1'b1;
		for (int n = 0; n <= NUM_ROWS; n++) begin
			if (n > 0) begin
				expect_true(grp_wr === rows[n-1].exp_wr,
					$sformatf("row %0d write lanes %h, expected %h",
						n - 1, grp_wr, rows[n-1].exp_wr));
				check_read(n - 1);
			end
			if (n < NUM_ROWS) begin
				apply_row(n);
			end
			@(negedge pll_afi_clk);
		end
		expect_true(exp_q.size() == 0, $sformatf("%0d reads never returned", exp_q.size()));
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: tb_phy_io_sva.sv
// Read valid and write lane assertions
`timescale 1ns/1ps

module tb_phy_io_sva import phy_io_pkg::*; (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic pop,
	input logic afi_rdata_valid,
	input grp_wr_t [NUM_DQS_GROUPS-1:0] grp_wr
);

	logic [NUM_DQS_GROUPS*NUM_HALVES-1:0] oe_bits;

	always_comb begin
		for (int g = 0; g < NUM_DQS_GROUPS; g++) begin
			oe_bits[g*NUM_HALVES +: NUM_HALVES] = grp_wr[g].oe;
		end
	end

	valid_low_in_reset: assert property (@(posedge pll_afi_clk)
		!reset_n_afi_clk |-> !afi_rdata_valid)
		else $error("afi_rdata_valid high while reset is asserted");

	// Pop, then lane_valid, then the registered AND
	valid_after_pop: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid |-> $past(pop, 2))
		else $error("afi_rdata_valid high without a pop two cycles earlier");

	oe_low_after_reset: assert property (@(posedge pll_afi_clk)
		$rose(reset_n_afi_clk) |-> (oe_bits == '0))
		else $error("write output enable set right after reset release");

endmodule

bind phy_io_top tb_phy_io_sva sva0 (
	.pll_afi_clk (pll_afi_clk),
	.reset_n_afi_clk (reset_n_afi_clk),
	.pop (pop),
	.afi_rdata_valid (afi_rdata_valid),
	.grp_wr (grp_wr)
);

// File: wr_lane_mux.sv
// Write lane regrouping
`timescale 1ns/1ps

module wr_lane_mux import phy_io_pkg::*; (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,

	input afi_wdata_t afi_wdata,
	input afi_dm_t afi_dm,
	input wr_ctrl_t wr_ctrl,

	output grp_wr_t [NUM_DQS_GROUPS-1:0] grp_wr
);

	dq_lane_t [NUM_DQS_GROUPS-1:0][NUM_SLOTS-1:0] dq_q;
	logic [NUM_DQS_GROUPS-1:0][NUM_SLOTS-1:0] dm_q;
	logic [NUM_DQS_GROUPS-1:0][NUM_HALVES-1:0] oe_q;
	logic [NUM_DQS_GROUPS-1:0][NUM_HALVES-1:0] dqs_en_q;
	logic [NUM_DQS_GROUPS-1:0][NUM_HALVES-1:0] oct_ena_q;

	// The AFI buses are ordered by time slot first and DQS group second,
	// so slot t of group g sits at index t*NUM_DQS_GROUPS+g
	always_ff @(posedge pll_afi_clk) begin
		for (int g = 0; g < NUM_DQS_GROUPS; g++) begin
			for (int t = 0; t < NUM_SLOTS; t++) begin
				dq_q[g][t] <= afi_wdata[(t*NUM_DQS_GROUPS+g)*DQ_PER_GROUP +: DQ_PER_GROUP];
				dm_q[g][t] <= afi_dm[t*NUM_DQS_GROUPS+g];
			end
		end
	end

	// Enables follow the same slot-major rule with one bit per half cycle
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			oe_q <= '0;
			dqs_en_q <= '0;
			oct_ena_q <= '0;
		end else begin
			for (int g = 0; g < NUM_DQS_GROUPS; g++) begin
				for (int h = 0; h < NUM_HALVES; h++) begin
					oe_q[g][h] <= wr_ctrl.wrdata_en[h*NUM_DQS_GROUPS+g];
					dqs_en_q[g][h] <= wr_ctrl.dqs_en[h*NUM_DQS_GROUPS+g];
					oct_ena_q[g][h] <= wr_ctrl.oct_ena[h*NUM_DQS_GROUPS+g];
				end
			end
		end
	end

	always_comb begin
		for (int g = 0; g < NUM_DQS_GROUPS; g++) begin
			grp_wr[g].dq = dq_q[g];
			grp_wr[g].dm = dm_q[g];
			grp_wr[g].oe = oe_q[g];
			grp_wr[g].dqs_en = dqs_en_q[g];
			grp_wr[g].oct_ena = oct_ena_q[g];
		end
	end

endmodule
